// ==== verilog/trap_pkg.sv ====
package trap_pkg;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Synchronous exception codes as written to mcause[4:0]
  typedef enum logic [4:0] {
    INSTR_FAULT     = 5'd1,
    ILLEGAL_INSN    = 5'd2,
    BREAKPOINT      = 5'd3,
    ECALL_MMODE     = 5'd11,
    INSTR_BUS_FAULT = 5'd24
  } exc_cause_e;

  // Protection unit result attached to each fetched instruction
  typedef enum logic [1:0] {
    MPU_OK,
    MPU_RE_FAULT,
    MPU_EXEC_FAULT
  } mpu_status_e;

  // Machine trap CSR addresses reachable through the write port
  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MIE     = 12'h304,
    CSR_MTVEC   = 12'h305,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342
  } csr_addr_e;

  // Trap controller FSM
  typedef enum logic [1:0] {
    CTRL_RUN,
    CTRL_TRAP,
    CTRL_MRET
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Instruction leaving the writeback stage
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] pc;
    logic        bus_err;
    mpu_status_e mpu_status;
    logic        illegal_insn;
    logic        ecall_insn;
    logic        ebrk_insn;
    logic        mret_insn;
  } ex_wb_pipe_t;

  // Architectural trap CSR state, mtvec[1:0] reads as zero
  typedef struct packed {
    logic        mstatus_mie;
    logic        mstatus_mpie;
    logic [31:0] mie_q;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;
  } csr_state_t;

  // Save or restore request, valid for the single cycle after acceptance
  typedef struct packed {
    logic        save_cause;
    logic        is_irq;
    logic [4:0]  cause;
    logic [31:0] epc;
    logic        restore;
  } trap_save_t;

  // Five exception mepc checks plus the interrupt enable check
  localparam int unsigned MON_ERR_W = 6;

endpackage

// ==== verilog/trap_ctrl.sv ====
`timescale 1ns/100ps

module trap_ctrl #(
  parameter int unsigned NUM_IRQ = 16
) (
  input  logic                  clk,
  input  logic                  rst_ni,

  // Writeback stage
  input  trap_pkg::ex_wb_pipe_t wb_i,
  input  logic                  kill_wb_i,

  // Interrupt levels
  input  logic [NUM_IRQ-1:0]    irq_i,

  // CSR view
  input  trap_pkg::csr_state_t  csr_state_i,
  input  logic [31:0]           mie_bypass_i,

  // Redirect and CSR update
  output trap_pkg::trap_save_t  save_o,
  output logic                  pc_set_o,
  output logic [31:0]           pc_o
);

  trap_pkg::ctrl_state_e state_q;
  trap_pkg::ctrl_state_e state_d;
  logic                  wb_live;
  logic                  exc_take;
  logic [4:0]            exc_cause;
  logic [NUM_IRQ-1:0]    irq_pend;
  logic [4:0]            irq_id;
  logic                  irq_take;
  logic                  mret_take;
  logic [31:0]           last_pc_q;
  logic [31:0]           tvec_base;
  trap_pkg::trap_save_t  save_d;
  logic                  pc_set_d;
  logic [31:0]           pc_d;

  // Instruction counts only when retiring outside the flush cycle
  assign wb_live = wb_i.instr_valid && !kill_wb_i && (state_q == trap_pkg::CTRL_RUN);

  // Vectored base, low mode bits never used
  assign tvec_base = {csr_state_i.mtvec[31:2], 2'b00};

  ////////////////////////////////////////////////////////////
  // Exception priority
  ////////////////////////////////////////////////////////////

  always_comb begin
    exc_take  = 1'b1;
    exc_cause = '0;
    // Fetch side faults first, then decode, then system instructions
    if (wb_i.mpu_status != trap_pkg::MPU_OK) begin
      exc_cause = trap_pkg::INSTR_FAULT;
    end else if (wb_i.bus_err) begin
      exc_cause = trap_pkg::INSTR_BUS_FAULT;
    end else if (wb_i.illegal_insn) begin
      exc_cause = trap_pkg::ILLEGAL_INSN;
    end else if (wb_i.ecall_insn) begin
      exc_cause = trap_pkg::ECALL_MMODE;
    end else if (wb_i.ebrk_insn) begin
      exc_cause = trap_pkg::BREAKPOINT;
    end else begin
      exc_take = 1'b0;
    end
    if (!wb_live) begin
      exc_take = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Interrupt selection
  ////////////////////////////////////////////////////////////

  // Bypassed mie so a disable written this cycle already masks the line
  assign irq_pend = irq_i & mie_bypass_i[NUM_IRQ-1:0];

  // Highest numbered pending line wins
  always_comb begin
    irq_id = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (irq_pend[i]) begin
        irq_id = 5'(i);
      end
    end
  end

  assign irq_take = (state_q == trap_pkg::CTRL_RUN) && !exc_take &&
                    csr_state_i.mstatus_mie && (|irq_pend);

  assign mret_take = wb_live && wb_i.mret_insn && !exc_take && !irq_take;

  ////////////////////////////////////////////////////////////
  // Next state and redirect
  ////////////////////////////////////////////////////////////

  always_comb begin
    // TRAP and MRET last one cycle while the pipeline flushes
    state_d  = trap_pkg::CTRL_RUN;
    save_d   = '0;
    pc_set_d = 1'b0;
    pc_d     = '0;
    if (exc_take) begin
      state_d           = trap_pkg::CTRL_TRAP;
      save_d.save_cause = 1'b1;
      save_d.cause      = exc_cause;
      save_d.epc        = wb_i.pc;
      pc_set_d          = 1'b1;
      pc_d              = tvec_base;
    end else if (irq_take) begin
      state_d           = trap_pkg::CTRL_TRAP;
      save_d.save_cause = 1'b1;
      save_d.is_irq     = 1'b1;
      save_d.cause      = irq_id;
      // No instruction in writeback, resume after the last one retired
      save_d.epc        = wb_live ? wb_i.pc : (last_pc_q + 32'd4);
      pc_set_d          = 1'b1;
      pc_d              = tvec_base + {25'd0, irq_id, 2'b00};
    end else if (mret_take) begin
      state_d        = trap_pkg::CTRL_MRET;
      save_d.restore = 1'b1;
      pc_set_d       = 1'b1;
      pc_d           = csr_state_i.mepc;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= trap_pkg::CTRL_RUN;
      save_o   <= '0;
      pc_set_o <= 1'b0;
    end else begin
      state_q  <= state_d;
      save_o   <= save_d;
      pc_set_o <= pc_set_d;
    end
  end

  // Target only meaningful alongside pc_set_o
  always_ff @(posedge clk) begin
    pc_o <= pc_d;
  end

  // Last retired PC for interrupts taken between instructions
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      last_pc_q <= '0;
    end else if (wb_live) begin
      last_pc_q <= wb_i.pc;
    end
  end

endmodule

// ==== verilog/trap_csr.sv ====
`timescale 1ns/100ps

module trap_csr #(
  parameter int unsigned NUM_IRQ = 16
) (
  input  logic                 clk,
  input  logic                 rst_ni,

  // Software write port
  input  logic                 csr_we_i,
  input  trap_pkg::csr_addr_e  csr_addr_i,
  input  logic [31:0]          csr_wdata_i,

  // Trap save or mret restore from the controller
  input  trap_pkg::trap_save_t save_i,

  // Observation
  output trap_pkg::csr_state_t csr_state_o,
  output logic [31:0]          mie_bypass_o
);

  // Only implemented interrupt lines have a writable enable
  localparam logic [31:0] MIE_MASK = (NUM_IRQ >= 32) ? 32'hffff_ffff :
                                     ((32'd1 << NUM_IRQ) - 32'd1);

  trap_pkg::csr_state_t csr_q;
  trap_pkg::csr_state_t csr_d;
  logic                 hw_upd;
  logic                 sw_wr;

  // Hardware update owns the cycle and drops any software write
  assign hw_upd = save_i.save_cause || save_i.restore;
  assign sw_wr  = csr_we_i && !hw_upd;

  ////////////////////////////////////////////////////////////
  // mie bypass
  ////////////////////////////////////////////////////////////

  // Value mie takes at the coming edge
  always_comb begin
    mie_bypass_o = csr_q.mie_q;
    if (sw_wr && (csr_addr_i == trap_pkg::CSR_MIE)) begin
      mie_bypass_o = csr_wdata_i & MIE_MASK;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next CSR state
  ////////////////////////////////////////////////////////////

  always_comb begin
    csr_d       = csr_q;
    csr_d.mie_q = mie_bypass_o;
    if (save_i.save_cause) begin
      // Trap entry stacks MIE and disables interrupts
      csr_d.mepc         = save_i.epc;
      csr_d.mcause       = {save_i.is_irq, 26'd0, save_i.cause};
      csr_d.mstatus_mpie = csr_q.mstatus_mie;
      csr_d.mstatus_mie  = 1'b0;
    end else if (save_i.restore) begin
      // mret pops MIE and leaves MPIE set
      csr_d.mstatus_mie  = csr_q.mstatus_mpie;
      csr_d.mstatus_mpie = 1'b1;
    end else if (sw_wr) begin
      case (csr_addr_i)
        trap_pkg::CSR_MSTATUS: begin
          // MIE in bit 3 and MPIE in bit 7
          csr_d.mstatus_mie  = csr_wdata_i[3];
          csr_d.mstatus_mpie = csr_wdata_i[7];
        end
        trap_pkg::CSR_MTVEC: begin
          csr_d.mtvec = {csr_wdata_i[31:2], 2'b00};
        end
        trap_pkg::CSR_MEPC: begin
          csr_d.mepc = csr_wdata_i;
        end
        trap_pkg::CSR_MCAUSE: begin
          csr_d.mcause = csr_wdata_i;
        end
        default: begin
          // mie handled through the bypass path
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_q              <= '0;
      // MPIE comes up set
      csr_q.mstatus_mpie <= 1'b1;
    end else begin
      csr_q <= csr_d;
    end
  end

  assign csr_state_o = csr_q;

endmodule

// ==== verilog/trap_monitor.sv ====
`timescale 1ns/100ps

module trap_monitor #(
  parameter int unsigned NUM_IRQ = 16
) (
  input  logic                           clk,
  input  logic                           rst_ni,

  // Retiring instruction as seen by the controller
  input  trap_pkg::ex_wb_pipe_t          wb_i,
  input  logic                           kill_wb_i,

  // Controller to CSR request
  input  trap_pkg::trap_save_t           save_i,

  // CSR view
  input  trap_pkg::csr_state_t           csr_state_i,
  input  logic [31:0]                    mie_bypass_i,

  // Sticky error flags
  output logic [trap_pkg::MON_ERR_W-1:0] err_o
);

  localparam int unsigned NUM_EXC = 5;

  // Error bit order illegal, ecall, ebreak, bus fault, protection fault
  localparam logic [4:0] EXC_CODE [NUM_EXC] = '{
    trap_pkg::ILLEGAL_INSN,
    trap_pkg::ECALL_MMODE,
    trap_pkg::BREAKPOINT,
    trap_pkg::INSTR_BUS_FAULT,
    trap_pkg::INSTR_FAULT
  };

  trap_pkg::ctrl_state_e             obs_state;
  logic                              retire_ok;
  logic                              mpu_flt;
  logic [NUM_EXC-1:0]                exp_hit;
  logic [NUM_EXC-1:0]                act_hit;
  logic [NUM_EXC-1:0]                exp_found_q;
  logic [NUM_EXC-1:0]                act_found_q;
  logic [NUM_EXC-1:0][31:0]          exp_pc_q;
  logic [NUM_EXC-1:0][31:0]          act_pc_q;
  logic [NUM_EXC-1:0]                mismatch;
  logic                              mie_prev_q;
  logic [31:0]                       bypass_prev_q;
  logic                              irq_bad;
  logic [trap_pkg::MON_ERR_W-1:0]    err_q;

  // Controller state rebuilt from its registered request
  assign obs_state = save_i.save_cause ? trap_pkg::CTRL_TRAP :
                     save_i.restore    ? trap_pkg::CTRL_MRET : trap_pkg::CTRL_RUN;

  assign retire_ok = wb_i.instr_valid && !kill_wb_i && (obs_state == trap_pkg::CTRL_RUN);
  assign mpu_flt   = (wb_i.mpu_status != trap_pkg::MPU_OK);

  ////////////////////////////////////////////////////////////
  // Expected side, one hit per instruction at most
  ////////////////////////////////////////////////////////////

  assign exp_hit[4] = retire_ok && mpu_flt;
  assign exp_hit[3] = retire_ok && !mpu_flt && wb_i.bus_err;
  assign exp_hit[0] = retire_ok && !mpu_flt && !wb_i.bus_err && wb_i.illegal_insn;
  assign exp_hit[1] = retire_ok && !mpu_flt && !wb_i.bus_err && !wb_i.illegal_insn &&
                      wb_i.ecall_insn;
  assign exp_hit[2] = retire_ok && !mpu_flt && !wb_i.bus_err && !wb_i.illegal_insn &&
                      !wb_i.ecall_insn && wb_i.ebrk_insn;

  ////////////////////////////////////////////////////////////
  // Per cause first occurrence latches
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NUM_EXC; k++) begin : g_cause
    // Actual side, exception saves only, interrupt ids can alias the codes
    assign act_hit[k] = save_i.save_cause && !save_i.is_irq &&
                        (save_i.cause == EXC_CODE[k]);

    always_ff @(posedge clk or negedge rst_ni) begin
      if (!rst_ni) begin
        exp_found_q[k] <= 1'b0;
        act_found_q[k] <= 1'b0;
      end else begin
        if (exp_hit[k]) exp_found_q[k] <= 1'b1;
        if (act_hit[k]) act_found_q[k] <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (exp_hit[k] && !exp_found_q[k]) begin
        exp_pc_q[k] <= wb_i.pc;
      end
      if (act_hit[k] && !act_found_q[k]) begin
        act_pc_q[k] <= save_i.epc;
      end
    end

    assign mismatch[k] = exp_found_q[k] && act_found_q[k] && (exp_pc_q[k] != act_pc_q[k]);
  end

  ////////////////////////////////////////////////////////////
  // Interrupt enable check
  ////////////////////////////////////////////////////////////

  // Save cycle follows acceptance, so judge the enables of the cycle before
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_prev_q    <= 1'b0;
      bypass_prev_q <= '0;
    end else begin
      mie_prev_q    <= csr_state_i.mstatus_mie;
      bypass_prev_q <= mie_bypass_i;
    end
  end

  assign irq_bad = save_i.save_cause && save_i.is_irq &&
                   (!mie_prev_q || !bypass_prev_q[save_i.cause] ||
                    (32'(save_i.cause) >= NUM_IRQ));

  // Sticky until reset
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= '0;
    end else begin
      err_q <= err_q | {irq_bad, mismatch};
    end
  end

  assign err_o = err_q;

endmodule

// ==== verilog/trap_unit.sv ====
`timescale 1ns/100ps

module trap_unit #(
  parameter int unsigned NUM_IRQ = 16
) (
  input  logic                           clk,
  input  logic                           rst_ni,

  // Writeback stage
  input  trap_pkg::ex_wb_pipe_t          wb_i,
  input  logic                           kill_wb_i,

  // Interrupt levels
  input  logic [NUM_IRQ-1:0]             irq_i,

  // CSR write port
  input  logic                           csr_we_i,
  input  trap_pkg::csr_addr_e            csr_addr_i,
  input  logic [31:0]                    csr_wdata_i,

  // PC redirect
  output logic                           pc_set_o,
  output logic [31:0]                    pc_o,

  // Observation
  output trap_pkg::csr_state_t           csr_o,
  output logic [trap_pkg::MON_ERR_W-1:0] mon_err_o
);

  trap_pkg::trap_save_t save;
  trap_pkg::csr_state_t csr_state;
  logic [31:0]          mie_bypass;

  ////////////////////////////////////////////////////////////
  // Controller, CSRs and checker
  ////////////////////////////////////////////////////////////

  trap_ctrl #(
    .NUM_IRQ      (NUM_IRQ)
  ) i_ctrl (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .wb_i         (wb_i),
    .kill_wb_i    (kill_wb_i),
    .irq_i        (irq_i),
    .csr_state_i  (csr_state),
    .mie_bypass_i (mie_bypass),
    .save_o       (save),
    .pc_set_o     (pc_set_o),
    .pc_o         (pc_o)
  );

  trap_csr #(
    .NUM_IRQ      (NUM_IRQ)
  ) i_csr (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .csr_we_i     (csr_we_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .save_i       (save),
    .csr_state_o  (csr_state),
    .mie_bypass_o (mie_bypass)
  );

  // Checks the mepc values saved against the instructions retired
  trap_monitor #(
    .NUM_IRQ      (NUM_IRQ)
  ) i_monitor (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .wb_i         (wb_i),
    .kill_wb_i    (kill_wb_i),
    .save_i       (save),
    .csr_state_i  (csr_state),
    .mie_bypass_i (mie_bypass),
    .err_o        (mon_err_o)
  );

  assign csr_o = csr_state;

endmodule

// ==== tests/trap_model.svh ====
// Highest priority exception of one instruction or zero when it raises none
function automatic logic [4:0] exc_cause_of(input trap_pkg::ex_wb_pipe_t w);
  logic [4:0] cause;
  // Lowest priority first so the most urgent condition overwrites
  cause = 5'd0;
  if (w.ebrk_insn) cause = trap_pkg::BREAKPOINT;
  if (w.ecall_insn) cause = trap_pkg::ECALL_MMODE;
  if (w.illegal_insn) cause = trap_pkg::ILLEGAL_INSN;
  if (w.bus_err) cause = trap_pkg::INSTR_BUS_FAULT;
  if (w.mpu_status != trap_pkg::MPU_OK) cause = trap_pkg::INSTR_FAULT;
  return cause;
endfunction

// Highest numbered set line or -1 when none
function automatic int highest_irq(input logic [31:0] pend);
  int line;
  line = -1;
  for (int i = 0; i < 32; i++) begin
    if (pend[i]) line = i;
  end
  return line;
endfunction

// Trap vector with interrupts spaced one word apart
function automatic logic [31:0] trap_target(input logic [31:0] tvec, input logic is_irq,
                                            input logic [4:0] line);
  logic [31:0] base;
  base = {tvec[31:2], 2'b00};
  if (is_irq) return base + 32'(line) * 32'd4;
  return base;
endfunction

// mie as seen after a write this cycle unless a pending save or restore blocks it
function automatic logic [31:0] mie_after_write(input trap_pkg::csr_state_t c,
    input trap_pkg::trap_save_t s, input logic we, input trap_pkg::csr_addr_e addr,
    input logic [31:0] wdata);
  if (we && (addr == trap_pkg::CSR_MIE) && !s.save_cause && !s.restore) begin
    return wdata & MIE_MASK;
  end
  return c.mie_q;
endfunction

// CSR contents after one edge
function automatic trap_pkg::csr_state_t csr_next(input trap_pkg::csr_state_t c,
    input trap_pkg::trap_save_t s, input logic we, input trap_pkg::csr_addr_e addr,
    input logic [31:0] wdata);
  trap_pkg::csr_state_t nxt;
  nxt       = c;
  nxt.mie_q = mie_after_write(c, s, we, addr, wdata);
  if (s.save_cause) begin
    nxt.mepc         = s.epc;
    nxt.mcause       = {s.is_irq, 26'd0, s.cause};
    nxt.mstatus_mpie = c.mstatus_mie;
    nxt.mstatus_mie  = 1'b0;
  end else if (s.restore) begin
    nxt.mstatus_mie  = c.mstatus_mpie;
    nxt.mstatus_mpie = 1'b1;
  end else if (we) begin
    case (addr)
      // Standard mstatus layout
      trap_pkg::CSR_MSTATUS: begin
        nxt.mstatus_mie  = wdata[3];
        nxt.mstatus_mpie = wdata[7];
      end
      trap_pkg::CSR_MTVEC: nxt.mtvec = {wdata[31:2], 2'b00};
      trap_pkg::CSR_MEPC: nxt.mepc = wdata;
      trap_pkg::CSR_MCAUSE: nxt.mcause = wdata;
      default: begin
      end
    endcase
  end
  return nxt;
endfunction

// ==== tests/tb_trap_unit.sv ====
`timescale 1ns/100ps

module tb_trap_unit;

  localparam int unsigned NUM_IRQ    = 16;
  localparam logic [31:0] MIE_MASK   = (32'd1 << NUM_IRQ) - 32'd1;
  localparam int          NUM_CYCLES = 4000;
  localparam int          DRAIN_MAX  = 8;

  logic                           clk = 1'b0;
  logic                           rst_ni;
  trap_pkg::ex_wb_pipe_t          wb;
  logic                           kill_wb;
  logic [NUM_IRQ-1:0]             irq;
  logic                           csr_we;
  trap_pkg::csr_addr_e            csr_addr;
  logic [31:0]                    csr_wdata;
  logic                           dut_pc_set;
  logic [31:0]                    dut_pc;
  trap_pkg::csr_state_t           dut_csr;
  logic [trap_pkg::MON_ERR_W-1:0] dut_err;

  // Model registers, hold the values expected after the last edge
  trap_pkg::ctrl_state_e m_state;
  trap_pkg::trap_save_t  m_save;
  trap_pkg::csr_state_t  m_csr;
  logic [31:0]           m_last_pc;
  logic                  m_pc_set;
  logic [31:0]           m_pc;

  // Event counts for a coverage sanity check
  int n_exc;
  int n_irq;
  int n_mret;
  int n_kill;
  int guard;

  integer seed = 32'hc324;

  `include "trap_model.svh"

  always #4 clk = ~clk;

  trap_unit #(
    .NUM_IRQ     (NUM_IRQ)
  ) i_dut (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .wb_i        (wb),
    .kill_wb_i   (kill_wb),
    .irq_i       (irq),
    .csr_we_i    (csr_we),
    .csr_addr_i  (csr_addr),
    .csr_wdata_i (csr_wdata),
    .pc_set_o    (dut_pc_set),
    .pc_o        (dut_pc),
    .csr_o       (dut_csr),
    .mon_err_o   (dut_err)
  );

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp_val, act_val);
      $display("Checks failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Registered outputs only, sampled 1 ns after the edge
  task automatic compare_outputs();
    check_value("pc_set_o", 32'(m_pc_set), 32'(dut_pc_set));
    if (m_pc_set) begin
      check_value("pc_o", m_pc, dut_pc);
    end
    check_value("mstatus_mie", 32'(m_csr.mstatus_mie), 32'(dut_csr.mstatus_mie));
    check_value("mstatus_mpie", 32'(m_csr.mstatus_mpie), 32'(dut_csr.mstatus_mpie));
    check_value("mie", m_csr.mie_q, dut_csr.mie_q);
    check_value("mtvec", m_csr.mtvec, dut_csr.mtvec);
    check_value("mepc", m_csr.mepc, dut_csr.mepc);
    check_value("mcause", m_csr.mcause, dut_csr.mcause);
    check_value("mon_err_o", 32'd0, 32'(dut_err));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_idle();
    wb        = '0;
    kill_wb   = 1'b0;
    irq       = '0;
    csr_we    = 1'b0;
    csr_addr  = trap_pkg::CSR_MSTATUS;
    csr_wdata = '0;
  endtask

  task automatic drive_random();
    logic [31:0]           r;
    trap_pkg::ex_wb_pipe_t w;
    w    = '0;
    r    = $random(seed);
    w.pc = {r[31:2], 2'b00};
    r    = $random(seed);
    // Several exception flags often overlap to stress the priority
    w.instr_valid  = (r[1:0] != 2'd0);
    w.bus_err      = (r[4:2] == 3'd0);
    w.illegal_insn = (r[8:5] == 4'd0);
    w.ecall_insn   = (r[12:9] == 4'd0);
    w.ebrk_insn    = (r[16:13] == 4'd0);
    w.mret_insn    = (r[19:17] == 3'd0);
    case (r[23:20])
      4'd0: w.mpu_status = trap_pkg::MPU_RE_FAULT;
      4'd1: w.mpu_status = trap_pkg::MPU_EXEC_FAULT;
      default: w.mpu_status = trap_pkg::MPU_OK;
    endcase
    wb      = w;
    kill_wb = (r[26:24] == 3'd0);
    r       = $random(seed);
    irq     = r[15:0] & r[31:16];
    r       = $random(seed);
    csr_we  = (r[1:0] == 2'd0);
    // mstatus and mie favoured so interrupts get enabled often
    case (r[4:2])
      3'd0: csr_addr = trap_pkg::CSR_MSTATUS;
      3'd1: csr_addr = trap_pkg::CSR_MIE;
      3'd2: csr_addr = trap_pkg::CSR_MTVEC;
      3'd3: csr_addr = trap_pkg::CSR_MEPC;
      3'd4: csr_addr = trap_pkg::CSR_MCAUSE;
      3'd5: csr_addr = trap_pkg::CSR_MSTATUS;
      default: csr_addr = trap_pkg::CSR_MIE;
    endcase
    csr_wdata = $random(seed);
  endtask

  ////////////////////////////////////////////////////////////
  // Model step for the inputs now applied
  ////////////////////////////////////////////////////////////

  task automatic model_step();
    logic                 live;
    logic [4:0]           cause;
    logic                 exc;
    logic [31:0]          bypass;
    int                   line;
    logic                 take_irq;
    logic                 take_mret;
    trap_pkg::trap_save_t save_n;
    live      = wb.instr_valid && !kill_wb && (m_state == trap_pkg::CTRL_RUN);
    cause     = exc_cause_of(wb);
    exc       = live && (cause != 5'd0);
    bypass    = mie_after_write(m_csr, m_save, csr_we, csr_addr, csr_wdata);
    line      = highest_irq(bypass & 32'(irq));
    take_irq  = (m_state == trap_pkg::CTRL_RUN) && !exc && m_csr.mstatus_mie && (line >= 0);
    take_mret = live && wb.mret_insn && !exc && !take_irq;
    save_n    = '0;
    m_pc_set  = exc || take_irq || take_mret;
    if (exc) begin
      save_n.save_cause = 1'b1;
      save_n.cause      = cause;
      save_n.epc        = wb.pc;
      m_pc              = trap_target(m_csr.mtvec, 1'b0, 5'd0);
      n_exc++;
    end else if (take_irq) begin
      save_n.save_cause = 1'b1;
      save_n.is_irq     = 1'b1;
      save_n.cause      = 5'(line);
      save_n.epc        = live ? wb.pc : (m_last_pc + 32'd4);
      m_pc              = trap_target(m_csr.mtvec, 1'b1, 5'(line));
      n_irq++;
    end else if (take_mret) begin
      save_n.restore = 1'b1;
      m_pc           = m_csr.mepc;
      n_mret++;
    end
    if (kill_wb && wb.instr_valid) n_kill++;
    // CSRs see the save registered last cycle
    m_csr   = csr_next(m_csr, m_save, csr_we, csr_addr, csr_wdata);
    m_save  = save_n;
    m_state = trap_pkg::CTRL_RUN;
    if (exc || take_irq) m_state = trap_pkg::CTRL_TRAP;
    if (take_mret) m_state = trap_pkg::CTRL_MRET;
    if (live) m_last_pc = wb.pc;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_ni = 1'b0;
    drive_idle();
    m_state            = trap_pkg::CTRL_RUN;
    m_save             = '0;
    m_csr              = '0;
    m_csr.mstatus_mpie = 1'b1;
    m_last_pc          = '0;
    m_pc_set           = 1'b0;
    m_pc               = '0;
    n_exc              = 0;
    n_irq              = 0;
    n_mret             = 0;
    n_kill             = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    for (int n = 0; n < NUM_CYCLES; n++) begin
      compare_outputs();
      drive_random();
      model_step();
      @(posedge clk);
      #1;
    end
    compare_outputs();
    // Let any redirect in flight finish
    drive_idle();
    guard = 0;
    while (m_pc_set || dut_pc_set || (m_state != trap_pkg::CTRL_RUN)) begin
      if (guard == DRAIN_MAX) begin
        $display("Trap unit kept redirecting the PC with idle inputs");
        $display("Checks failed");
        $fatal(1, "drain timeout");
      end
      model_step();
      @(posedge clk);
      #1;
      compare_outputs();
      guard++;
    end
    check_value("mon_err_o at end", 32'd0, 32'(dut_err));
    $display("Exceptions %0d, interrupts %0d, mret %0d, killed %0d",
             n_exc, n_irq, n_mret, n_kill);
    if ((n_exc == 0) || (n_irq == 0) || (n_mret == 0) || (n_kill == 0)) begin
      $display("Random run missed exceptions, interrupts, mret or killed instructions");
      $display("Checks failed");
      $fatal(1, "stimulus coverage too low");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// ==== build.f ====
+incdir+tests
verilog/trap_pkg.sv
verilog/trap_ctrl.sv
verilog/trap_csr.sv
verilog/trap_monitor.sv
verilog/trap_unit.sv
tests/tb_trap_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build the trap unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f build.f \
  --top-module tb_trap_unit -Mdir obj_dir -o tb_trap_unit
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_trap_unit
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

echo "Simulation ended normally"
exit 0
